// ==== sim.f ====
+incdir+rtl
rtl/ray_box_pkg.sv
rtl/slab_interval.sv
rtl/slab_flag_delay.sv
rtl/slab_hit_decide.sv
rtl/ray_box_top.sv
sim/tb_ray_box.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the ray/box testbench with Verilator
cd "$(dirname "$0")" || exit 1
set -o pipefail

verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module tb_ray_box \
	-o tb_ray_box > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_ray_box | tee sim.log || { echo "simulation exited with an error"; exit 1; }

grep -q "Some tests failed" sim.log && { echo "result: FAIL"; exit 1; }
grep -q "All tests passed" sim.log || { echo "result: no pass line in log"; exit 1; }
echo "result: PASS"

// ==== sim/tb_ray_box.sv ====
`timescale 1ns/1ps
`include "ray_box_macros.svh"

module tb_ray_box import ray_box_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 5;
	localparam int LATENCY = 5; // edges from the driving negedge to valid outputs
	localparam int ONE = 1 << `RAY_FRAC_W; // 1.0 in Q7.8
	localparam int DIRECTED_RAYS = 10;
	localparam int RANDOM_RAYS = 200;
	localparam int NUM_TESTS = 6;
	localparam int WATCHDOG_CYCLES = 2 * RESET_CYCLES + DIRECTED_RAYS + RANDOM_RAYS
		+ NUM_TESTS * (LATENCY + 2) + 20;

	logic clk;
	logic rst;
	coord_t org_x, org_y, org_z;
	coord_t lo_x, lo_y, lo_z;
	coord_t hi_x, hi_y, hi_z;
	coord_t inv_x, inv_y, inv_z;
	logic par_x, par_y, par_z;
	t_t t_near;
	t_t t_far;
	logic hit;

	coord_t org_v [`RAY_AXES]; // next ray, one entry per axis
	coord_t lo_v [`RAY_AXES];
	coord_t hi_v [`RAY_AXES];
	coord_t inv_v [`RAY_AXES];
	logic [`RAY_AXES-1:0] par_v;

	t_t exp_near_q [$];
	t_t exp_far_q [$];
	logic exp_hit_q [$];
	int due_q [$]; // edge count at which each result is valid
	int edge_count = 0;
	int error_count = 0;
	int check_count = 0;

	ray_box_top u_dut (
		.clk(clk), .rst(rst),
		.org_x(org_x), .org_y(org_y), .org_z(org_z),
		.lo_x(lo_x), .lo_y(lo_y), .lo_z(lo_z),
		.hi_x(hi_x), .hi_y(hi_y), .hi_z(hi_z),
		.inv_x(inv_x), .inv_y(inv_y), .inv_z(inv_z),
		.par_x(par_x), .par_y(par_y), .par_z(par_z),
		.t_near(t_near), .t_far(t_far), .hit(hit)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) edge_count <= edge_count + 1;

	//////////////////////////////////////////////////
	// reference model and checks
	//////////////////////////////////////////////////

	function automatic void ray_model(output t_t near_o, output t_t far_o, output logic hit_o);
		longint near_l;
		longint far_l;
		longint t_a;
		longint t_b;
		longint tmp;
		logic blocked;
		near_l = longint'(`RAY_T_MIN);
		far_l = longint'(`RAY_T_MAX);
		blocked = 1'b0;
		for (int a = 0; a < `RAY_AXES; a++) begin
			if (par_v[a]) begin
				if (org_v[a] < lo_v[a] || org_v[a] > hi_v[a]) blocked = 1'b1;
			end else begin
				t_a = ((longint'(lo_v[a]) - longint'(org_v[a])) * longint'(inv_v[a]))
					>>> `RAY_FRAC_W;
				t_b = ((longint'(hi_v[a]) - longint'(org_v[a])) * longint'(inv_v[a]))
					>>> `RAY_FRAC_W;
				if (longint'(inv_v[a]) < 0) begin // entry through the upper corner
					tmp = t_a;
					t_a = t_b;
					t_b = tmp;
				end
				if (t_a > near_l) near_l = t_a;
				if (t_b < far_l) far_l = t_b;
			end
		end
		near_o = t_t'(near_l);
		far_o = t_t'(far_l);
		hit_o = !blocked && (far_l >= near_l) && (far_l > 0);
	endfunction

	task automatic check_t(input string name, input t_t got, input t_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_hit(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[FAIL] t=%0t %s got %0b expected %0b", $time, name, got, exp);
		end
	endtask

	// results are stable at the falling edge
	always @(negedge clk) begin
		if (due_q.size() > 0 && due_q[0] == edge_count) begin
			check_t("t_near", t_near, exp_near_q[0]);
			check_t("t_far", t_far, exp_far_q[0]);
			check_hit("hit", hit, exp_hit_q[0]);
			exp_near_q.delete(0);
			exp_far_q.delete(0);
			exp_hit_q.delete(0);
			due_q.delete(0);
		end
	end

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////

	// values in 1/256 units
	task automatic set_axis(input int a, input int o, input int l, input int h, input int r,
			input logic p);
		org_v[a] = coord_t'(o);
		lo_v[a] = coord_t'(l);
		hi_v[a] = coord_t'(h);
		inv_v[a] = coord_t'(r);
		par_v[a] = p;
	endtask

	task automatic drive_inputs();
		org_x = org_v[0];
		org_y = org_v[1];
		org_z = org_v[2];
		lo_x = lo_v[0];
		lo_y = lo_v[1];
		lo_z = lo_v[2];
		hi_x = hi_v[0];
		hi_y = hi_v[1];
		hi_z = hi_v[2];
		inv_x = inv_v[0];
		inv_y = inv_v[1];
		inv_z = inv_v[2];
		{par_z, par_y, par_x} = par_v;
	endtask

	task automatic send_ray();
		t_t near_e;
		t_t far_e;
		logic hit_e;
		@(negedge clk);
		drive_inputs(); // one ray per call, back to back when called in a loop
		ray_model(near_e, far_e, hit_e);
		exp_near_q.push_back(near_e);
		exp_far_q.push_back(far_e);
		exp_hit_q.push_back(hit_e);
		due_q.push_back(edge_count + LATENCY);
	endtask

	task automatic drain_pipe();
		while (due_q.size() != 0) @(negedge clk);
	endtask

	function automatic int rand_span(input int span);
		return int'($urandom_range(0, 2 * span)) - span;
	endfunction

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	task automatic reset_outputs();
		// hitting ray held on the inputs while in reset
		for (int a = 0; a < `RAY_AXES; a++) set_axis(a, 0, ONE, 3 * ONE, ONE, 1'b0);
		rst = 1'b1;
		drive_inputs();
		for (int c = 0; c < RESET_CYCLES + LATENCY + 1; c++) begin
			@(negedge clk);
			if (c == RESET_CYCLES - 1) begin
				rst = 1'b0; // released away from the rising edge
				for (int a = 0; a < `RAY_AXES; a++) set_axis(a, 0, 0, 0, 0, 1'b0);
				drive_inputs();
			end
			check_t("t_near", t_near, '0);
			check_t("t_far", t_far, '0);
			check_hit("hit", hit, 1'b0);
		end
	endtask

	task automatic direct_hit();
		for (int a = 0; a < `RAY_AXES; a++) set_axis(a, 0, ONE, 3 * ONE, ONE, 1'b0);
		send_ray();
		set_axis(0, -2 * ONE, 0, 4 * ONE, ONE / 2, 1'b0);
		set_axis(1, ONE / 2, ONE, 2 * ONE, 2 * ONE, 1'b0);
		set_axis(2, ONE, 3 * ONE / 2, 5 * ONE, ONE, 1'b0);
		send_ray();
		drain_pipe();
	endtask

	task automatic negative_direction();
		for (int a = 0; a < `RAY_AXES; a++) set_axis(a, 5 * ONE, ONE, 3 * ONE, -ONE, 1'b0);
		send_ray();
		set_axis(1, 5 * ONE, ONE, 3 * ONE, -ONE / 4, 1'b0); // y interval ends before x starts
		send_ray();
		set_axis(0, -ONE, ONE, 3 * ONE, ONE, 1'b0);
		set_axis(1, 5 * ONE, ONE, 3 * ONE, -ONE, 1'b0);
		set_axis(2, 2 * ONE, ONE, 3 * ONE, -2 * ONE, 1'b0);
		send_ray();
		drain_pipe();
	endtask

	task automatic parallel_axes();
		set_axis(0, 5 * ONE, ONE, 3 * ONE, 0, 1'b1);
		set_axis(1, 0, ONE, 3 * ONE, ONE, 1'b0);
		set_axis(2, 0, ONE, 3 * ONE, ONE, 1'b0);
		send_ray();
		set_axis(0, 2 * ONE, ONE, 3 * ONE, 0, 1'b1);
		send_ray();
		for (int a = 0; a < `RAY_AXES; a++) set_axis(a, 2 * ONE, ONE, 3 * ONE, 0, 1'b1);
		send_ray();
		drain_pipe();
	endtask

	task automatic box_behind();
		for (int a = 0; a < `RAY_AXES; a++) set_axis(a, 5 * ONE, ONE, 3 * ONE, ONE, 1'b0);
		send_ray();
		for (int a = 0; a < `RAY_AXES; a++) set_axis(a, 3 * ONE, ONE, 3 * ONE, ONE, 1'b0);
		send_ray(); // exit exactly at the origin
		drain_pipe();
	endtask

	task automatic random_stream();
		int l;
		for (int n = 0; n < RANDOM_RAYS; n++) begin
			for (int a = 0; a < `RAY_AXES; a++) begin
				if (n % 4 == 3) begin
					set_axis(a, int'($urandom), int'($urandom), int'($urandom), int'($urandom),
						1'($urandom_range(0, 1)));
				end else begin
					l = rand_span(16 * ONE);
					set_axis(a, rand_span(24 * ONE), l, l + int'($urandom_range(0, 16 * ONE)),
						rand_span(4 * ONE), $urandom_range(0, 7) == 0);
				end
			end
			send_ray();
		end
		drain_pipe();
	endtask

	initial begin
		void'($urandom(32'h164a));
		rst = 1'b1;
		{org_x, org_y, org_z, lo_x, lo_y, lo_z} = '0;
		{hi_x, hi_y, hi_z, inv_x, inv_y, inv_z} = '0;
		{par_x, par_y, par_z} = '0;
		reset_outputs();
		direct_hit();
		negative_direction();
		parallel_axes();
		box_behind();
		random_stream();
		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired at t=%0t, results still pending: %0d", $time, due_q.size());
		$display("Some tests failed");
		$finish;
	end

endmodule

// ==== rtl/ray_box_top.sv ====
`timescale 1ns/1ps
`include "ray_box_macros.svh"

module ray_box_top import ray_box_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  coord_t org_x,
	input  coord_t org_y,
	input  coord_t org_z,
	input  coord_t lo_x,
	input  coord_t lo_y,
	input  coord_t lo_z,
	input  coord_t hi_x,
	input  coord_t hi_y,
	input  coord_t hi_z,
	input  coord_t inv_x,
	input  coord_t inv_y,
	input  coord_t inv_z,
	input  logic   par_x,
	input  logic   par_y,
	input  logic   par_z,
	output t_t     t_near,
	output t_t     t_far,
	output logic   hit
);

	t_t t_lo_x;
	t_t t_hi_x;
	t_t t_lo_y;
	t_t t_hi_y;
	t_t t_lo_z;
	t_t t_hi_z;
	logic out_x;
	logic out_y;
	logic out_z;
	logic [`RAY_AXES-1:0] par_d;
	logic [`RAY_AXES-1:0] out_d;

	//////////////////////////////////////////////////
	// 3 cycles, slab distances per axis
	//////////////////////////////////////////////////

	slab_interval u_slab (
		.clk    (clk),
		.rst    (rst),
		.org_x  (org_x),
		.org_y  (org_y),
		.org_z  (org_z),
		.lo_x   (lo_x),
		.lo_y   (lo_y),
		.lo_z   (lo_z),
		.hi_x   (hi_x),
		.hi_y   (hi_y),
		.hi_z   (hi_z),
		.inv_x  (inv_x),
		.inv_y  (inv_y),
		.inv_z  (inv_z),
		.t_lo_x (t_lo_x),
		.t_hi_x (t_hi_x),
		.t_lo_y (t_lo_y),
		.t_hi_y (t_hi_y),
		.t_lo_z (t_lo_z),
		.t_hi_z (t_hi_z),
		.out_x  (out_x),
		.out_y  (out_y),
		.out_z  (out_z)
	);

	slab_flag_delay u_flags (
		.clk   (clk),
		.rst   (rst),
		.par_x (par_x),
		.par_y (par_y),
		.par_z (par_z),
		.out_x (out_x),
		.out_y (out_y),
		.out_z (out_z),
		.par_d (par_d),
		.out_d (out_d)
	);

	//////////////////////////////////////////////////
	// 2 cycles, reduction and hit
	//////////////////////////////////////////////////

	slab_hit_decide u_decide (
		.clk    (clk),
		.rst    (rst),
		.t_lo_x (t_lo_x),
		.t_hi_x (t_hi_x),
		.t_lo_y (t_lo_y),
		.t_hi_y (t_hi_y),
		.t_lo_z (t_lo_z),
		.t_hi_z (t_hi_z),
		.par_d  (par_d),
		.out_d  (out_d),
		.t_near (t_near),
		.t_far  (t_far),
		.hit    (hit)
	);

endmodule

// ==== rtl/slab_hit_decide.sv ====
`timescale 1ns/1ps
`include "ray_box_macros.svh"

module slab_hit_decide import ray_box_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  t_t                   t_lo_x,
	input  t_t                   t_hi_x,
	input  t_t                   t_lo_y,
	input  t_t                   t_hi_y,
	input  t_t                   t_lo_z,
	input  t_t                   t_hi_z,
	input  logic [`RAY_AXES-1:0] par_d,
	input  logic [`RAY_AXES-1:0] out_d,
	output t_t                   t_near,
	output t_t                   t_far,
	output logic                 hit
);

	t_t t_lo [`RAY_AXES];
	t_t t_hi [`RAY_AXES];
	t_t near_c;
	t_t far_c;
	t_t near_r;
	t_t far_r;
	logic blocked_r; // parallel axis with origin outside its slab

	assign t_lo[0] = t_lo_x;
	assign t_lo[1] = t_lo_y;
	assign t_lo[2] = t_lo_z;
	assign t_hi[0] = t_hi_x;
	assign t_hi[1] = t_hi_y;
	assign t_hi[2] = t_hi_z;

	//////////////////////////////////////////////////
	// reduction over the non-parallel axes
	//////////////////////////////////////////////////

	always_comb begin
		near_c = `RAY_T_MIN; // all parallel leaves the full line
		far_c = `RAY_T_MAX;
		for (int a = 0; a < `RAY_AXES; a++) begin
			if (!par_d[a]) begin
				if (t_lo[a] > near_c) begin
					near_c = t_lo[a]; // latest entry
				end
				if (t_hi[a] < far_c) begin
					far_c = t_hi[a]; // earliest exit
				end
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			near_r <= '0;
			far_r <= '0;
			blocked_r <= 1'b0;
		end else begin
			near_r <= near_c;
			far_r <= far_c;
			blocked_r <= |(par_d & out_d);
		end
	end

	//////////////////////////////////////////////////
	// hit rule
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			t_near <= '0;
			t_far <= '0;
			hit <= 1'b0;
		end else begin
			t_near <= near_r;
			t_far <= far_r;
			// intervals overlap and the box is not behind the origin
			hit <= !blocked_r && (far_r >= near_r) && (far_r > 0);
		end
	end

endmodule

// ==== rtl/slab_flag_delay.sv ====
`timescale 1ns/1ps
`include "ray_box_macros.svh"

module slab_flag_delay (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 par_x,
	input  logic                 par_y,
	input  logic                 par_z,
	input  logic                 out_x,
	input  logic                 out_y,
	input  logic                 out_z,
	output logic [`RAY_AXES-1:0] par_d,
	output logic [`RAY_AXES-1:0] out_d
);

	// three taps, one per slab_interval stage
	logic [`RAY_AXES-1:0] par_s1;
	logic [`RAY_AXES-1:0] par_s2;
	logic [`RAY_AXES-1:0] out_s1;
	logic [`RAY_AXES-1:0] out_s2;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			par_s1 <= '0;
			par_s2 <= '0;
			par_d <= '0;
			out_s1 <= '0;
			out_s2 <= '0;
			out_d <= '0;
		end else begin
			par_s1 <= {par_z, par_y, par_x}; // bit 0 is x
			par_s2 <= par_s1;
			par_d <= par_s2; // lines up with the ordered distances
			out_s1 <= {out_z, out_y, out_x};
			out_s2 <= out_s1;
			out_d <= out_s2;
		end
	end

endmodule

// ==== rtl/slab_interval.sv ====
`timescale 1ns/1ps
`include "ray_box_macros.svh"

module slab_interval import ray_box_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  coord_t org_x,
	input  coord_t org_y,
	input  coord_t org_z,
	input  coord_t lo_x,
	input  coord_t lo_y,
	input  coord_t lo_z,
	input  coord_t hi_x,
	input  coord_t hi_y,
	input  coord_t hi_z,
	input  coord_t inv_x,
	input  coord_t inv_y,
	input  coord_t inv_z,
	output t_t     t_lo_x,
	output t_t     t_hi_x,
	output t_t     t_lo_y,
	output t_t     t_hi_y,
	output t_t     t_lo_z,
	output t_t     t_hi_z,
	output logic   out_x,
	output logic   out_y,
	output logic   out_z
);

	localparam int DIFF_W = `RAY_COORD_W + 1; // corner minus origin needs one more bit
	localparam int PROD_W = `RAY_T_W + `RAY_FRAC_W;

	coord_t org [`RAY_AXES];
	coord_t lo [`RAY_AXES];
	coord_t hi [`RAY_AXES];
	coord_t inv [`RAY_AXES];
	logic [`RAY_AXES-1:0] out_flag;

	logic signed [DIFF_W-1:0] diff_lo_r [`RAY_AXES]; // stage 1
	logic signed [DIFF_W-1:0] diff_hi_r [`RAY_AXES];
	coord_t inv_r [`RAY_AXES];
	logic signed [PROD_W-1:0] prod_lo_r [`RAY_AXES]; // stage 2
	logic signed [PROD_W-1:0] prod_hi_r [`RAY_AXES];
	logic [`RAY_AXES-1:0] neg_r;
	t_t t_lo_r [`RAY_AXES]; // stage 3
	t_t t_hi_r [`RAY_AXES];

	assign org[0] = org_x;
	assign org[1] = org_y;
	assign org[2] = org_z;
	assign lo[0] = lo_x;
	assign lo[1] = lo_y;
	assign lo[2] = lo_z;
	assign hi[0] = hi_x;
	assign hi[1] = hi_y;
	assign hi[2] = hi_z;
	assign inv[0] = inv_x;
	assign inv[1] = inv_y;
	assign inv[2] = inv_z;

	// origin outside the slab, taken at entry and delayed outside
	always_comb begin
		for (int a = 0; a < `RAY_AXES; a++) begin
			out_flag[a] = (org[a] < lo[a]) || (org[a] > hi[a]);
		end
	end

	assign out_x = out_flag[0];
	assign out_y = out_flag[1];
	assign out_z = out_flag[2];

	//////////////////////////////////////////////////
	// stage 1, differences
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int a = 0; a < `RAY_AXES; a++) begin
				diff_lo_r[a] <= '0;
				diff_hi_r[a] <= '0;
				inv_r[a] <= '0;
			end
		end else begin
			for (int a = 0; a < `RAY_AXES; a++) begin
				diff_lo_r[a] <= DIFF_W'(lo[a]) - DIFF_W'(org[a]);
				diff_hi_r[a] <= DIFF_W'(hi[a]) - DIFF_W'(org[a]);
				inv_r[a] <= inv[a];
			end
		end
	end

	//////////////////////////////////////////////////
	// stage 2, products
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int a = 0; a < `RAY_AXES; a++) begin
				prod_lo_r[a] <= '0;
				prod_hi_r[a] <= '0;
			end
			neg_r <= '0;
		end else begin
			for (int a = 0; a < `RAY_AXES; a++) begin
				prod_lo_r[a] <= PROD_W'(diff_lo_r[a]) * PROD_W'(inv_r[a]);
				prod_hi_r[a] <= PROD_W'(diff_hi_r[a]) * PROD_W'(inv_r[a]);
				neg_r[a] <= inv_r[a][`RAY_COORD_W-1]; // ray runs toward -axis
			end
		end
	end

	//////////////////////////////////////////////////
	// stage 3, realign and order
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int a = 0; a < `RAY_AXES; a++) begin
				t_lo_r[a] <= '0;
				t_hi_r[a] <= '0;
			end
		end else begin
			for (int a = 0; a < `RAY_AXES; a++) begin
				// dropping the low bits floors toward -inf
				if (neg_r[a]) begin
					t_lo_r[a] <= prod_hi_r[a][PROD_W-1:`RAY_FRAC_W]; // swapped
					t_hi_r[a] <= prod_lo_r[a][PROD_W-1:`RAY_FRAC_W];
				end else begin
					t_lo_r[a] <= prod_lo_r[a][PROD_W-1:`RAY_FRAC_W];
					t_hi_r[a] <= prod_hi_r[a][PROD_W-1:`RAY_FRAC_W];
				end
			end
		end
	end

	assign t_lo_x = t_lo_r[0];
	assign t_hi_x = t_hi_r[0];
	assign t_lo_y = t_lo_r[1];
	assign t_hi_y = t_hi_r[1];
	assign t_lo_z = t_lo_r[2];
	assign t_hi_z = t_hi_r[2];

endmodule

// ==== rtl/ray_box_pkg.sv ====
`include "ray_box_macros.svh"

package ray_box_pkg;

	//////////////////////////////////////////////////
	// input side
	//////////////////////////////////////////////////

	// origin, box corners and reciprocal direction share one format
	typedef logic signed [`RAY_COORD_W-1:0] coord_t; // Q7.8

	//////////////////////////////////////////////////
	// distance side
	//////////////////////////////////////////////////

	// distance along the ray, diff * inv with the fraction realigned
	typedef logic signed [`RAY_T_W-1:0] t_t; // also t_near / t_far

endpackage

// ==== rtl/ray_box_macros.svh ====
`ifndef RAY_BOX_MACROS_SVH
`define RAY_BOX_MACROS_SVH

//////////////////////////////////////////////////
// fixed-point format
//////////////////////////////////////////////////

`define RAY_COORD_W 16 // origin, corner and reciprocal width
`define RAY_FRAC_W 8 // fraction bits, same for every value
`define RAY_T_W 26 // slab distance width

`define RAY_AXES 3 // x, y, z

//////////////////////////////////////////////////
// distance limits, stand-ins for -inf and +inf
//////////////////////////////////////////////////

`define RAY_T_MIN ($signed({1'b1, {(`RAY_T_W-1){1'b0}}}))
`define RAY_T_MAX ($signed({1'b0, {(`RAY_T_W-1){1'b1}}}))

`endif
